//--- run.sh
#!/bin/sh
# Build and run the exception pipeline testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb -f tb.f -o simTb || { echo "Build failed"; exit 1; }
./obj_dir/simTb +verilator+error+limit+100 > sim.log 2>&1 || echo "Simulator returned an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

//--- src/cp0Pkg.sv
package cp0Pkg;

	////////////////////////////////////////
	// Basic types
	////////////////////////////////////////

	// Pcs, instructions and register values
	typedef logic [31:0] word;

	// Cause.ExcCode values, zero is both interrupt and none
	typedef enum logic [4:0] {
		excInt = 5'd0,
		excAdEL = 5'd4,
		excRI = 5'd10,
		excOv = 5'd12
	} excCode;

	// Coprocessor 0 register numbers
	localparam logic [4:0] regSR = 5'd12;
	localparam logic [4:0] regCause = 5'd13;
	localparam logic [4:0] regEPC = 5'd14;
	localparam logic [4:0] regPRId = 5'd15;

	////////////////////////////////////////
	// Opcode and field values
	////////////////////////////////////////

	localparam logic [5:0] opSpecial = 6'd0;
	localparam logic [5:0] opJ = 6'd2;
	localparam logic [5:0] opJal = 6'd3;
	localparam logic [5:0] opBeq = 6'd4;
	localparam logic [5:0] opBne = 6'd5;
	localparam logic [5:0] opAddi = 6'd8;
	localparam logic [5:0] opOri = 6'd13;
	localparam logic [5:0] opLui = 6'd15;
	localparam logic [5:0] opCop0 = 6'd16;

	// Funct codes under special, plus eret under cop0
	localparam logic [5:0] fnSll = 6'd0;
	localparam logic [5:0] fnJr = 6'd8;
	localparam logic [5:0] fnJalr = 6'd9;
	localparam logic [5:0] fnEret = 6'd24;
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnAddu = 6'd33;

	// Cop0 rs codes, rsCo marks the coprocessor operation group
	localparam logic [4:0] rsMf = 5'd0;
	localparam logic [4:0] rsMt = 5'd4;
	localparam logic [4:0] rsCo = 5'd16;

	// Bit positions inside SR and Cause
	localparam int imHi = 15;
	localparam int imLo = 10;
	localparam int exlBit = 1;
	localparam int ieBit = 0;
	localparam int ipHi = 15;
	localparam int ipLo = 10;
	localparam int excCodeHi = 6;
	localparam int excCodeLo = 2;
	localparam int bdBit = 31;

endpackage

//--- src/cp0Regs.sv
module cp0Regs #(
	parameter cp0Pkg::word prIdValue = 32'h0001_9300
) (
	input logic clk,
	input logic reset,
	input cp0Pkg::word pcD,
	input cp0Pkg::word pcE,
	input cp0Pkg::word pcM,
	input logic validD,
	input logic validE,
	input logic validM,
	input logic slotD,
	input logic slotE,
	input logic slotM,
	input logic pendingM,
	input cp0Pkg::excCode codeM,
	input cp0Pkg::word instrM,
	input logic mtc0,
	input logic eret,
	input logic [5:0] hwInt,
	input cp0Pkg::word cp0WriteData,
	output cp0Pkg::word cp0ReadData,
	output logic [29:0] epc,
	output logic excTaken
);
	import cp0Pkg::*;

	// Architectural registers
	word sr;
	word cause;
	word epcReg;
	word prId;

	logic [4:0] rd;
	logic [5:0] im;
	logic exl;
	logic ie;
	logic intReq;
	logic excReq;
	logic mtc0Wr;
	logic restartSlot;
	word restartPc;
	word epcNext;
	word srWrite;
	excCode takenCode;

	// Field views
	assign rd = instrM[15:11];
	assign im = sr[imHi:imLo];
	assign exl = sr[exlBit];
	assign ie = sr[ieBit];

	// Flushed or bubble slots never write
	assign mtc0Wr = validM && mtc0;

	////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////

	// Interrupt straight from the request lines
	assign intReq = (|(hwInt & im)) && ie && !exl;

	// Faults are taken only from M
	assign excReq = validM && pendingM && !exl;

	assign excTaken = intReq || excReq;

	// Interrupt wins and records code zero
	assign takenCode = intReq ? excInt : codeM;

	////////////////////////////////////////
	// Restart pc
	////////////////////////////////////////

	// Oldest valid instruction among M, E and D
	always_comb begin
		if (validM) begin
			restartPc = pcM;
			restartSlot = slotM;
		end else if (validE) begin
			restartPc = pcE;
			restartSlot = slotE;
		end else begin
			restartPc = pcD;
			restartSlot = slotD && validD;
		end
	end

	// Slot instruction restarts at its branch
	assign epcNext = restartSlot ? (restartPc - 32'd4) : restartPc;

	// SR write keeps IM, EXL and IE only
	always_comb begin
		srWrite = '0;
		srWrite[imHi:imLo] = cp0WriteData[imHi:imLo];
		srWrite[exlBit] = cp0WriteData[exlBit];
		srWrite[ieBit] = cp0WriteData[ieBit];
	end

	////////////////////////////////////////
	// Register update
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sr <= '0;
			cause <= '0;
			epcReg <= '0;
			prId <= prIdValue;
		end else begin
			// Pending lines tracked every cycle
			cause[ipHi:ipLo] <= hwInt;

			// SR: mtc0, then eret, then exception entry
			if (mtc0Wr && rd == regSR) begin
				sr <= srWrite;
			end else if (eret) begin
				sr[exlBit] <= 1'b0;
			end else if (excTaken && !mtc0Wr) begin
				sr[exlBit] <= 1'b1;
			end

			// EPC, word aligned on exception entry
			if (mtc0Wr && rd == regEPC) begin
				epcReg <= cp0WriteData;
			end else if (excTaken && !mtc0Wr) begin
				epcReg <= {epcNext[31:2], 2'b00};
			end

			// Cause recording skipped when mtc0 owns the cycle
			if (excTaken && !mtc0Wr) begin
				cause[bdBit] <= restartSlot;
				cause[excCodeHi:excCodeLo] <= takenCode;
			end
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	// mfc0 data from rd of the M instruction
	always_comb begin
		case (rd)
			regSR: cp0ReadData = sr;
			regCause: cp0ReadData = cause;
			regEPC: cp0ReadData = epcReg;
			regPRId: cp0ReadData = prId;
			default: cp0ReadData = '0;
		endcase
	end

	assign epc = epcReg[31:2];

endmodule

//--- src/excPipe.sv
module excPipe #(
	parameter cp0Pkg::word prIdValue = 32'h0001_9300,
	parameter cp0Pkg::word textBase = 32'h0000_3000,
	parameter cp0Pkg::word textLimit = 32'h0000_5000
) (
	input logic clk,
	input logic reset,
	input cp0Pkg::word pc,
	input cp0Pkg::word instr,
	input logic fetchValid,
	input logic ovfE,
	input logic [5:0] hwInt,
	input cp0Pkg::word cp0WriteData,
	output cp0Pkg::word cp0ReadData,
	output logic [29:0] epc,
	output logic excTaken
);
	import cp0Pkg::*;

	// Decode of the incoming fetch
	excCode decCode;
	logic decPending;
	logic decBranch;

	// Stage outputs, delaySlot field holds "own instr is a branch"
	word pcD;
	word pcE;
	word pcM;
	word pcW;
	word instrD;
	word instrE;
	word instrM;
	word instrW;
	logic validD;
	logic validE;
	logic validM;
	logic validW;
	logic branchD;
	logic branchE;
	logic branchM;
	logic branchW;
	excCode codeD;
	excCode codeE;
	excCode codeM;
	logic pendingD;
	logic pendingE;
	logic pendingM;
	logic mtc0M;
	logic eretW;

	////////////////////////////////////////
	// Decode at the D register input
	////////////////////////////////////////

	instrDecode #(.textBase(textBase), .textLimit(textLimit)) decD (
		.pc(pc), .instr(instr), .mtc0(), .mfc0(), .eret(),
		.isBranch(decBranch), .code(decCode), .excPending(decPending)
	);

	// Flush also drops the fetch presented on that edge
	excStage stageD (
		.clk(clk), .reset(reset), .flush(excTaken),
		.inPc(pc), .inInstr(instr), .inValid(fetchValid), .inDelaySlot(decBranch),
		.inCode(excInt), .inPending(1'b0), .newPending(decPending), .newCode(decCode),
		.pc(pcD), .instr(instrD), .valid(validD), .delaySlot(branchD),
		.code(codeD), .pending(pendingD)
	);

	excStage stageE (
		.clk(clk), .reset(reset), .flush(excTaken),
		.inPc(pcD), .inInstr(instrD), .inValid(validD), .inDelaySlot(branchD),
		.inCode(codeD), .inPending(pendingD), .newPending(1'b0), .newCode(excInt),
		.pc(pcE), .instr(instrE), .valid(validE), .delaySlot(branchE),
		.code(codeE), .pending(pendingE)
	);

	// Overflow belongs to the instr in execute, merged on its way to M
	excStage stageM (
		.clk(clk), .reset(reset), .flush(excTaken),
		.inPc(pcE), .inInstr(instrE), .inValid(validE), .inDelaySlot(branchE),
		.inCode(codeE), .inPending(pendingE), .newPending(ovfE), .newCode(excOv),
		.pc(pcM), .instr(instrM), .valid(validM), .delaySlot(branchM),
		.code(codeM), .pending(pendingM)
	);

	// Faulting M instr never reaches write-back
	excStage stageW (
		.clk(clk), .reset(reset), .flush(excTaken),
		.inPc(pcM), .inInstr(instrM), .inValid(validM), .inDelaySlot(branchM),
		.inCode(codeM), .inPending(pendingM), .newPending(1'b0), .newCode(excInt),
		.pc(pcW), .instr(instrW), .valid(validW), .delaySlot(branchW),
		.code(), .pending()
	);

	////////////////////////////////////////
	// Coprocessor 0
	////////////////////////////////////////

	instrDecode #(.textBase(textBase), .textLimit(textLimit)) decM (
		.pc(pcM), .instr(instrM), .mtc0(mtc0M), .mfc0(), .eret(),
		.isBranch(), .code(), .excPending()
	);

	// Bubble in W decodes as sll, so no stray eret
	instrDecode #(.textBase(textBase), .textLimit(textLimit)) decW (
		.pc(pcW), .instr(validW ? instrW : '0), .mtc0(), .mfc0(), .eret(eretW),
		.isBranch(), .code(), .excPending()
	);

	// Slot flag of a stage is the branch flag of the next older stage
	cp0Regs #(.prIdValue(prIdValue)) cp0 (
		.clk(clk), .reset(reset),
		.pcD(pcD), .pcE(pcE), .pcM(pcM),
		.validD(validD), .validE(validE), .validM(validM),
		.slotD(branchE & validE), .slotE(branchM & validM), .slotM(branchW & validW),
		.pendingM(pendingM), .codeM(codeM), .instrM(instrM),
		.mtc0(mtc0M), .eret(eretW), .hwInt(hwInt), .cp0WriteData(cp0WriteData),
		.cp0ReadData(cp0ReadData), .epc(epc), .excTaken(excTaken)
	);

endmodule

//--- src/excStage.sv
module excStage (
	input logic clk,
	input logic reset,
	input logic flush,
	input cp0Pkg::word inPc,
	input cp0Pkg::word inInstr,
	input logic inValid,
	input logic inDelaySlot,
	input cp0Pkg::excCode inCode,
	input logic inPending,
	input logic newPending,
	input cp0Pkg::excCode newCode,
	output cp0Pkg::word pc,
	output cp0Pkg::word instr,
	output logic valid,
	output logic delaySlot,
	output cp0Pkg::excCode code,
	output logic pending
);

	logic takeNew;

	// Only a clean valid instruction picks up a fault raised here
	// An older fault keeps its code, so decode beats overflow
	assign takeNew = inValid && !inPending && newPending;

	////////////////////////////////////////
	// Control state
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			valid <= 1'b0;
			pending <= 1'b0;
		end else begin
			valid <= inValid;
			// Bubbles never carry a fault
			pending <= inValid && (inPending || newPending);
		end
	end

	////////////////////////////////////////
	// Payload
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		pc <= inPc;
		instr <= inInstr;
		delaySlot <= inDelaySlot;
		// Meaningful only while pending is set
		code <= takeNew ? newCode : inCode;
	end

endmodule

//--- src/instrDecode.sv
module instrDecode #(
	parameter cp0Pkg::word textBase = 32'h0000_3000,
	parameter cp0Pkg::word textLimit = 32'h0000_5000
) (
	input cp0Pkg::word pc,
	input cp0Pkg::word instr,
	output logic mtc0,
	output logic mfc0,
	output logic eret,
	output logic isBranch,
	output cp0Pkg::excCode code,
	output logic excPending
);
	import cp0Pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic known;
	logic badPc;

	// Instruction fields
	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs = instr[25:21];

	////////////////////////////////////////
	// Classification
	////////////////////////////////////////

	always_comb begin
		mtc0 = 1'b0;
		mfc0 = 1'b0;
		eret = 1'b0;
		isBranch = 1'b0;
		known = 1'b1;
		case (opcode)
			opSpecial: begin
				case (funct)
					fnSll, fnAdd, fnAddu: known = 1'b1;
					// Register jumps own a delay slot too
					fnJr, fnJalr: isBranch = 1'b1;
					default: known = 1'b0;
				endcase
			end
			opAddi, opOri, opLui: known = 1'b1;
			opBeq, opBne, opJ, opJal: isBranch = 1'b1;
			opCop0: begin
				if (rs == rsMf) begin
					mfc0 = 1'b1;
				end else if (rs == rsMt) begin
					mtc0 = 1'b1;
				end else if (rs == rsCo && funct == fnEret) begin
					eret = 1'b1;
				end else begin
					known = 1'b0;
				end
			end
			default: known = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// Decode faults
	////////////////////////////////////////

	// Misaligned, or outside [textBase, textLimit)
	assign badPc = (pc[1:0] != 2'b00) || (pc < textBase) || (pc >= textLimit);

	// Fetch address error beats reserved instruction
	assign code = badPc ? excAdEL : (!known ? excRI : excInt);
	assign excPending = badPc || !known;

endmodule

//--- tb.f
src/cp0Pkg.sv
src/instrDecode.sv
src/excStage.sv
src/cp0Regs.sv
src/excPipe.sv
tests/excPipe_props.sv
tests/tb.sv

//--- tests/excPipe_props.sv
module excPipeProps (
	input logic clk,
	input logic reset,
	input logic excTaken,
	input logic eretW,
	input cp0Pkg::word sr,
	input cp0Pkg::word epcReg,
	input cp0Pkg::word prId
);
	import cp0Pkg::*;

	// Failure tally, read by the testbench at the end
	int errCount;

	initial begin
		errCount = 0;
	end

	////////////////////////////////////////
	// Reset and exception level
	////////////////////////////////////////

	// Quiet in the second reset cycle and the one after reset
	resetQuiet: assert property (@(posedge clk) reset |=> !excTaken)
		else begin
			errCount++;
			$error("excTaken high during reset or in the cycle after it");
		end

	// No nested entry while EXL holds
	exlBlocks: assert property (@(posedge clk) disable iff (reset)
		(sr[exlBit] && !eretW) |-> !excTaken)
		else begin
			errCount++;
			$error("exception taken while EXL was set");
		end

	////////////////////////////////////////
	// Register contents
	////////////////////////////////////////

	// Word aligned restart address
	epcAligned: assert property (@(posedge clk) disable iff (reset) epcReg[1:0] == 2'b00)
		else begin
			errCount++;
			$error("EPC low bits are not zero");
		end

	// Read only id
	prIdFixed: assert property (@(posedge clk) disable iff (reset) $stable(prId))
		else begin
			errCount++;
			$error("PRId changed outside reset");
		end

endmodule

bind excPipe excPipeProps props (
	.clk(clk), .reset(reset), .excTaken(excTaken), .eretW(eretW),
	.sr(cp0.sr), .epcReg(cp0.epcReg), .prId(cp0.prId)
);

//--- tests/tb.sv
module tb;
	import cp0Pkg::*;

	localparam word prIdValue = 32'h0001_9300;
	localparam word textBase = 32'h0000_3000;
	localparam word textLimit = 32'h0000_5000;
	// Tests run close to 200 cycles
	localparam int cycleLimit = 400;

	// Encodings of the instructions used
	localparam word nopInstr = 32'h0000_0000;
	localparam word addInstr = {opSpecial, 5'd1, 5'd2, 5'd3, 5'd0, fnAdd};
	localparam word beqInstr = {opBeq, 5'd1, 5'd2, 16'd4};
	localparam word eretInstr = {opCop0, rsCo, 15'd0, fnEret};
	localparam word rsvdInstr = {6'd63, 26'd0};

	logic clk;
	logic reset;
	word pc;
	word instr;
	logic fetchValid;
	logic ovfE;
	logic [5:0] hwInt;
	word cp0WriteData;
	word cp0ReadData;
	logic [29:0] epc;
	logic excTaken;

	// Stimulus state
	word nextPc;
	word wdata;
	logic [5:0] hwHold;
	logic [31:0] seed;
	int cycles;
	int errors;
	int testStart;
	int passCount;
	int failCount;

	excPipe #(.prIdValue(prIdValue), .textBase(textBase), .textLimit(textLimit)) UUT (
		.clk(clk), .reset(reset), .pc(pc), .instr(instr), .fetchValid(fetchValid),
		.ovfE(ovfE), .hwInt(hwInt), .cp0WriteData(cp0WriteData),
		.cp0ReadData(cp0ReadData), .epc(epc), .excTaken(excTaken)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: no end of tests after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic word mfc0Of(input logic [4:0] rd);
		return {opCop0, rsMf, 5'd8, rd, 11'd0};
	endfunction

	function automatic word mtc0Of(input logic [4:0] rd);
		return {opCop0, rsMt, 5'd8, rd, 11'd0};
	endfunction

	// Expected SR from its three fields
	function automatic word srOf(input logic [5:0] im, input logic exl, input logic ie);
		word w;
		w = '0;
		w[imHi:imLo] = im;
		w[exlBit] = exl;
		w[ieBit] = ie;
		return w;
	endfunction

	// Expected Cause, IP mirrors the request lines
	function automatic word causeOf(input logic bd, input logic [4:0] code, input logic [5:0] ip);
		word w;
		w = '0;
		w[bdBit] = bd;
		w[excCodeHi:excCodeLo] = code;
		w[ipHi:ipLo] = ip;
		return w;
	endfunction

	task automatic checkWord(input string name, input word exp, input word act);
		assert (act === exp) else begin
			$display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic checkTaken(input logic exp);
		checkWord("excTaken", {31'd0, exp}, {31'd0, excTaken});
	endtask

	// Drive on the falling edge, then settle before the next rise
	task automatic issueAt(input word p, input word i, input logic o);
		@(negedge clk);
		pc = p;
		instr = i;
		fetchValid = 1'b1;
		ovfE = o;
		hwInt = hwHold;
		cp0WriteData = wdata;
		#10;
	endtask

	task automatic issue(input word i, input logic o);
		issueAt(nextPc, i, o);
		nextPc = nextPc + 32'd4;
	endtask

	// mfc0 data shows three cycles after presentation
	task automatic readReg(input logic [4:0] rd, input word exp, input string name);
		issue(mfc0Of(rd), 1'b0);
		repeat (3) issue(nopInstr, 1'b0);
		checkWord(name, exp, cp0ReadData);
	endtask

	// Written on the edge that ends the M cycle
	task automatic writeReg(input logic [4:0] rd, input word val);
		wdata = val;
		issue(mtc0Of(rd), 1'b0);
		repeat (3) issue(nopInstr, 1'b0);
	endtask

	task automatic endTest(input string name);
		if (errors == testStart) begin
			passCount++;
			$display("Test %s: pass", name);
		end else begin
			failCount++;
			$display("Test %s: fail with %0d mismatches", name, errors - testStart);
		end
		testStart = errors;
	endtask

	////////////////////////////////////////
	// Test bodies
	////////////////////////////////////////

	// Decode fault taken from M, younger instrs dropped
	task automatic faultCase(input word faultPc, input word faultInstr, input logic [4:0] code);
		writeReg(regSR, 32'h0);
		issueAt(faultPc, faultInstr, 1'b0);
		nextPc = nextPc + 32'd4;
		repeat (2) begin
			issue(nopInstr, 1'b0);
			checkTaken(1'b0);
		end
		// Overflow aimed at the younger ones
		issue(nopInstr, 1'b1);
		checkTaken(1'b1);
		repeat (3) begin
			issue(nopInstr, 1'b1);
			checkTaken(1'b0);
		end
		checkWord("epc", {faultPc[31:2], 2'b00}, {epc, 2'b00});
		readReg(regCause, causeOf(1'b0, code, 6'd0), "Cause");
		readReg(regEPC, {faultPc[31:2], 2'b00}, "EPC");
		readReg(regSR, srOf(6'd0, 1'b1, 1'b0), "SR");
	endtask

	// Overflow on an add, after a beq or not
	task automatic ovfCase(input logic withBranch);
		word victimPc;
		writeReg(regSR, 32'h0);
		issue(withBranch ? beqInstr : nopInstr, 1'b0);
		victimPc = nextPc;
		issue(addInstr, 1'b0);
		issue(nopInstr, 1'b0);
		checkTaken(1'b0);
		// add sits in E now
		issue(nopInstr, 1'b1);
		checkTaken(1'b0);
		issue(nopInstr, 1'b0);
		checkTaken(1'b1);
		readReg(regCause, causeOf(withBranch, excOv, 6'd0), "Cause");
		readReg(regEPC, withBranch ? victimPc - 32'd4 : victimPc, "EPC");
	endtask

	initial begin
		word val;
		word intPc;
		int line;
		int otherIdx;
		logic [5:0] imBit;
		logic [5:0] otherBit;

		reset = 1'b1;
		pc = '0;
		instr = '0;
		fetchValid = 1'b0;
		ovfE = 1'b0;
		hwInt = '0;
		cp0WriteData = '0;
		nextPc = textBase;
		wdata = '0;
		hwHold = '0;
		seed = 32'd33;
		cycles = 0;
		errors = 0;
		testStart = 0;
		passCount = 0;
		failCount = 0;

		repeat (2) @(negedge clk);
		reset = 1'b0;

		// 1. Reset values
		#10;
		checkTaken(1'b0);
		checkWord("epc", 32'h0, {2'b00, epc});
		readReg(regSR, 32'h0, "SR");
		readReg(regCause, 32'h0, "Cause");
		readReg(regEPC, 32'h0, "EPC");
		readReg(regPRId, prIdValue, "PRId");
		endTest("reset state");

		// 2. Only IM, EXL and IE survive
		repeat (2) begin
			seed = lcgNext(seed);
			val = seed;
			writeReg(regSR, val);
			readReg(regSR, val & srOf(6'h3f, 1'b1, 1'b1), "SR");
		end
		writeReg(regSR, 32'h0);
		readReg(regSR, 32'h0, "SR");
		endTest("SR write masking");

		// 3. RI, then AdEL on a misaligned fetch
		faultCase(nextPc, rsvdInstr, excRI);
		faultCase(nextPc + 32'd2, nopInstr, excAdEL);
		endTest("decode faults");

		// 4. BD set only behind a branch
		ovfCase(1'b1);
		ovfCase(1'b0);
		endTest("delay slot and overflow");

		// 5. One random IM line, another line outside it
		seed = lcgNext(seed);
		line = seed % 32'd6;
		seed = lcgNext(seed);
		otherIdx = (line + 1 + (seed % 32'd5)) % 6;
		imBit = 6'b000001 << line;
		otherBit = 6'b000001 << otherIdx;
		writeReg(regSR, srOf(imBit, 1'b0, 1'b1));
		hwHold = otherBit;
		repeat (3) begin
			issue(nopInstr, 1'b0);
			checkTaken(1'b0);
		end
		hwHold = imBit;
		issue(nopInstr, 1'b0);
		checkTaken(1'b1);
		// Oldest valid instr was presented three cycles back
		intPc = nextPc - 32'd16;
		// Held request while EXL is set
		repeat (3) begin
			issue(nopInstr, 1'b0);
			checkTaken(1'b0);
		end
		readReg(regCause, causeOf(1'b0, excInt, imBit), "Cause");
		readReg(regEPC, intPc, "EPC");
		endTest("interrupts");

		// 6. eret clears EXL from W, held request comes back
		issue(eretInstr, 1'b0);
		checkTaken(1'b0);
		repeat (4) begin
			issue(nopInstr, 1'b0);
			checkTaken(1'b0);
		end
		issue(nopInstr, 1'b0);
		checkTaken(1'b1);
		intPc = nextPc - 32'd16;
		hwHold = '0;
		repeat (2) issue(nopInstr, 1'b0);
		readReg(regEPC, intPc, "EPC");
		readReg(regSR, srOf(imBit, 1'b1, 1'b1), "SR");
		endTest("eret");

		$display("Tests passed: %0d, failed: %0d, property failures: %0d",
			passCount, failCount, UUT.props.errCount);
		if (errors == 0 && UUT.props.errCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
